/* arcade_board.f */
hw/board_pkg.sv
hw/reset_stretch.sv
hw/input_cond.sv
hw/control_keys.sv
hw/dip_decode.sv
hw/board_top.sv
sim/board_sva.sv
sim/board_tb.sv

/* hw/board_pkg.sv */
// Board control package with widths, bit maps, reset length and shared types
`default_nettype none

package board_pkg;

    // Reset stretch
    localparam int RST_HOLD_CYCLES = 256;          // Cycles of core reset after last trigger
    localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES);
    localparam logic [RST_CNT_W-1:0] RST_CNT_MAX = RST_CNT_W'(RST_HOLD_CYCLES - 1);

    // Game input polarity
    localparam bit INPUTS_ACTIVE_LOW = 1'b1;

    // Joystick widths
    localparam int JOY_W       = 10;
    localparam int BOARD_JOY_W = 16;

    // Three-button layout is fixed off on this board
    localparam int THREE_BUTTONS = 0;
    localparam int START1_BIT    = 6 + THREE_BUTTONS;
    localparam int START2_BIT    = 7 + THREE_BUTTONS;
    localparam int COIN_BIT      = 8 + THREE_BUTTONS;
    localparam int PAUSE_BIT     = 9 + THREE_BUTTONS;

    localparam int GFX_LAYERS = 4;

    // Status word map
    localparam int STATUS_W  = 32;
    localparam int FX_W      = 2;
    localparam int ST_ROT    = 2;   // Rotate controls
    localparam int ST_FX_LSB = 5;
    localparam int ST_NO_FM  = 8;
    localparam int ST_NO_PSG = 9;
    localparam int ST_TEST   = 10;
    localparam int ST_FLIP   = 12;

    typedef logic [JOY_W-1:0]       joy_t;
    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [STATUS_W-1:0]    status_t;

    // Decoded keyboard, all active high
    typedef struct packed {
        joy_t                  joy1;
        joy_t                  joy2;
        logic [1:0]            start;
        logic [1:0]            coin;
        logic                  reset;
        logic                  pause;
        logic                  service;
        logic [GFX_LAYERS-1:0] gfx;
    } key_t;

    // Inputs seen by the game, all active low
    typedef struct packed {
        joy_t       joy1;
        joy_t       joy2;
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
    } game_in_t;

    typedef struct packed {
        logic            pause_n;       // Low while paused
        logic            flip;
        logic            test;
        logic [FX_W-1:0] fxlevel;
        logic            rot_control;
        logic            enable_fm;
        logic            enable_psg;
    } dip_t;

endpackage

`default_nettype wire

/* hw/board_top.sv */
// Arcade board control top, joining reset, input, key and settings logic
`default_nettype none

module board_top
    import board_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  game_rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  board_joy_t            board_joy1,
    input  board_joy_t            board_joy2,
    input  key_t                  keys,
    input  status_t               status,
    output logic                  core_rst,
    output logic                  core_rst_n,
    output game_in_t              game_in,
    output dip_t                  dip,
    output logic [GFX_LAYERS-1:0] gfx_en
);

    logic joy_pause;    // Either joystick pause button
    logic game_pause;
    logic soft_rst;     // One cycle pulse from the reset key

    reset_stretch u_reset (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .downloading ( downloading ),
        .rst_req     ( rst_req     ),
        .soft_rst    ( soft_rst    ),
        .flip        ( dip.flip    ),
        .core_rst    ( core_rst    ),
        .core_rst_n  ( core_rst_n  )
    );

    input_cond u_input (
        .clk_sys     ( clk_sys         ),
        .game_rst    ( game_rst        ),
        .board_joy1  ( board_joy1      ),
        .board_joy2  ( board_joy2      ),
        .keys        ( keys            ),
        .rot_control ( dip.rot_control ),
        .game_in     ( game_in         ),
        .joy_pause   ( joy_pause       )
    );

    control_keys u_ctrl (
        .clk_sys    ( clk_sys    ),
        .game_rst   ( game_rst   ),
        .key_pause  ( keys.pause ),
        .key_reset  ( keys.reset ),
        .key_gfx    ( keys.gfx   ),
        .joy_pause  ( joy_pause  ),
        .game_pause ( game_pause ),
        .soft_rst   ( soft_rst   ),
        .gfx_en     ( gfx_en     )
    );

    dip_decode u_dip (
        .clk_sys    ( clk_sys    ),
        .game_rst   ( game_rst   ),
        .status     ( status     ),
        .game_pause ( game_pause ),
        .dip        ( dip        )
    );

endmodule

`default_nettype wire

/* hw/control_keys.sv */
// Key edge detection for pause, graphics layer toggles and soft reset
`default_nettype none

module control_keys
    import board_pkg::*;
(
    input  logic                  clk_sys,
    input  logic                  game_rst,
    input  logic                  key_pause,
    input  logic                  key_reset,
    input  logic [GFX_LAYERS-1:0] key_gfx,
    input  logic                  joy_pause,
    output logic                  game_pause,
    output logic                  soft_rst,
    output logic [GFX_LAYERS-1:0] gfx_en
);

    logic                  last_pause;
    logic                  last_joy_pause;
    logic                  last_reset;
    logic [GFX_LAYERS-1:0] last_gfx;
    logic                  pause_edge;
    logic [GFX_LAYERS-1:0] gfx_edge;

    // Previous levels for edge detection
    always_ff @(posedge clk_sys) begin
        last_pause     <= key_pause;
        last_joy_pause <= joy_pause;
        last_reset     <= key_reset;
        last_gfx       <= key_gfx;
    end

    // Both sources together count as one press
    assign pause_edge = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign gfx_edge   = key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_pause <= 1'b0;
            soft_rst   <= 1'b0;
            gfx_en     <= '1;       // All layers shown
        end else begin
            soft_rst <= key_reset & ~last_reset;
            gfx_en   <= gfx_en ^ gfx_edge;
            if (pause_edge) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dip_decode.sv */
// Settings decoder from the status word, merged with the pause state
`default_nettype none

module dip_decode
    import board_pkg::*;
(
    input  logic    clk_sys,
    input  logic    game_rst,
    input  status_t status,
    input  logic    game_pause,
    output dip_t    dip
);

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            dip         <= '0;
            dip.pause_n <= 1'b1;    // Running after reset
        end else begin
            dip.pause_n     <= ~game_pause;
            dip.flip        <= status[ST_FLIP];
            dip.test        <= status[ST_TEST];
            dip.fxlevel     <= status[ST_FX_LSB +: FX_W];
            dip.rot_control <= status[ST_ROT];
            dip.enable_fm   <= ~status[ST_NO_FM];   // Status holds disable bits
            dip.enable_psg  <= ~status[ST_NO_PSG];
        end
    end

endmodule

`default_nettype wire

/* hw/input_cond.sv */
// Player input conditioner with sync, keyboard merge, rotation and polarity
`default_nettype none

module input_cond
    import board_pkg::*;
(
    input  logic       clk_sys,
    input  logic       game_rst,
    input  board_joy_t board_joy1,
    input  board_joy_t board_joy2,
    input  key_t       keys,
    input  logic       rot_control,
    output game_in_t   game_in,
    output logic       joy_pause
);

    board_joy_t joy1_sync;
    board_joy_t joy2_sync;
    logic [1:0] joy_coin;
    logic [1:0] joy_start;

    // Swap directions for vertical games
    function automatic joy_t apply_rotation(input joy_t joy_in, input logic rot);
        joy_t rotated;
        rotated = joy_in;
        if (rot) begin
            rotated[1:0] = {joy_in[0], joy_in[1]};
            rotated[3:2] = {joy_in[2], joy_in[3]};
        end
        return rotated ^ {JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    // Board joysticks come in asynchronously
    always_ff @(posedge clk_sys) begin
        joy1_sync <= board_joy1;
        joy2_sync <= board_joy2;
    end

    assign joy_pause = joy1_sync[PAUSE_BIT] | joy2_sync[PAUSE_BIT];

    assign joy_coin  = {joy2_sync[COIN_BIT], joy1_sync[COIN_BIT]};
    assign joy_start = {joy1_sync[START2_BIT], joy1_sync[START1_BIT]}
                     | {joy2_sync[START2_BIT], joy2_sync[START1_BIT]};

    always_ff @(posedge clk_sys) begin
        if (game_rst) begin
            game_in <= {$bits(game_in_t){INPUTS_ACTIVE_LOW}};   // All inputs released
        end else begin
            game_in.joy1    <= apply_rotation(joy1_sync[JOY_W-1:0] | keys.joy1, rot_control);
            game_in.joy2    <= apply_rotation(joy2_sync[JOY_W-1:0] | keys.joy2, rot_control);
            game_in.coin    <= (joy_coin | keys.coin) ^ {2{INPUTS_ACTIVE_LOW}};
            game_in.start   <= (joy_start | keys.start) ^ {2{INPUTS_ACTIVE_LOW}};
            game_in.service <= keys.service ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

`default_nettype wire

/* hw/reset_stretch.sv */
// Core reset generator, restarted by any reset source and held for a fixed count
`default_nettype none

module reset_stretch
    import board_pkg::*;
(
    input  logic clk_sys,
    input  logic game_rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    input  logic flip,
    output logic core_rst,
    output logic core_rst_n
);

    logic                 last_flip;
    logic                 trigger;
    logic [RST_CNT_W-1:0] rst_cnt;
    logic                 pre_rst_n;

    // A flip change restarts the game as well
    assign trigger = game_rst | downloading | rst_req | soft_rst | (flip != last_flip);

    always_ff @(posedge clk_sys) begin
        last_flip <= flip;
    end

    // Counter saturates at its maximum, reset held until then
    always_ff @(posedge clk_sys) begin
        if (trigger) begin
            rst_cnt  <= '0;
            core_rst <= 1'b1;
        end else if (rst_cnt != RST_CNT_MAX) begin
            rst_cnt  <= rst_cnt + 1'b1;
            core_rst <= 1'b1;
        end else begin
            core_rst <= 1'b0;
        end
    end

    // Active-low copy trails the release by two cycles
    always_ff @(posedge clk_sys) begin
        if (trigger || core_rst) begin
            pre_rst_n  <= 1'b0;
            core_rst_n <= 1'b0;
        end else begin
            pre_rst_n  <= 1'b1;
            core_rst_n <= pre_rst_n;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build the arcade board testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -Wno-fatal \
    --top-module board_tb \
    -f arcade_board.f \
    -o board_sim

./obj_dir/board_sim

/* sim/board_sva.sv */
// Concurrent assertions on reset polarity, the soft reset pulse and reset values
`default_nettype none

module board_sva
    import board_pkg::*;
(
    input logic                  clk_sys,
    input logic                  game_rst,
    input logic                  core_rst,
    input logic                  core_rst_n,
    input logic                  soft_rst,
    input logic [GFX_LAYERS-1:0] gfx_en,
    input dip_t                  dip
);
    timeunit 1ns;
    timeprecision 1ps;

    // Both reset outputs must agree while the core is held
    rst_polarity: assert property (@(posedge clk_sys) core_rst |-> !core_rst_n)
        else $error("core_rst_n high while core_rst is active");

    soft_rst_pulse: assert property (@(posedge clk_sys) soft_rst |=> !soft_rst)
        else $error("soft_rst lasted more than one cycle");

    // Layers shown and game running right after reset
    reset_values: assert property (@(posedge clk_sys)
        game_rst |=> (gfx_en == '1) && dip.pause_n)
        else $error("gfx_en or pause_n wrong after game_rst");

endmodule

bind board_top board_sva u_sva (
    .clk_sys    ( clk_sys    ),
    .game_rst   ( game_rst   ),
    .core_rst   ( core_rst   ),
    .core_rst_n ( core_rst_n ),
    .soft_rst   ( soft_rst   ),
    .gfx_en     ( gfx_en     ),
    .dip        ( dip        )
);

`default_nettype wire

/* sim/board_tb.sv */
// Directed testbench for the arcade board control logic
`default_nettype none

module board_tb
    import board_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Test 1 spans three stretches, tests 2 and 6 one each, the rest are short
    localparam int TIMEOUT_CYCLES = 4000;

    logic                  clk_sys;
    logic                  game_rst;
    logic                  rst_req;
    logic                  downloading;
    board_joy_t            board_joy1;
    board_joy_t            board_joy2;
    key_t                  keys;
    status_t               status;
    logic                  core_rst;
    logic                  core_rst_n;
    game_in_t              game_in;
    dip_t                  dip;
    logic [GFX_LAYERS-1:0] gfx_en;

    logic [31:0]           lcg_state = 32'd57;
    int                    cycle_count = 0;
    logic                  paused;      // Expected pause state
    logic [GFX_LAYERS-1:0] layers;      // Expected layer enables

    board_top UUT (
        .clk_sys     ( clk_sys     ),
        .game_rst    ( game_rst    ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .board_joy1  ( board_joy1  ),
        .board_joy2  ( board_joy2  ),
        .keys        ( keys        ),
        .status      ( status      ),
        .core_rst    ( core_rst    ),
        .core_rst_n  ( core_rst_n  ),
        .game_in     ( game_in     ),
        .dip         ( dip         ),
        .gfx_en      ( gfx_en      )
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Verification failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    function automatic logic [31:0] random_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected game joystick after merge, optional direction swap and inversion
    function automatic joy_t expect_joy(input board_joy_t board, input joy_t key, input logic rot);
        joy_t merged;
        merged = board[JOY_W-1:0] | key;
        if (rot) begin
            merged = {merged[JOY_W-1:4], merged[2], merged[3], merged[0], merged[1]};
        end
        return ~merged;
    endfunction

    function automatic game_in_t expect_game_in(input board_joy_t b1, input board_joy_t b2,
                                                input key_t k, input logic rot);
        game_in_t e;
        e.joy1     = expect_joy(b1, k.joy1, rot);
        e.joy2     = expect_joy(b2, k.joy2, rot);
        e.coin[0]  = ~(b1[COIN_BIT] | k.coin[0]);
        e.coin[1]  = ~(b2[COIN_BIT] | k.coin[1]);
        e.start[0] = ~(b1[START1_BIT] | b2[START1_BIT] | k.start[0]);
        e.start[1] = ~(b1[START2_BIT] | b2[START2_BIT] | k.start[1]);
        e.service  = ~k.service;
        return e;
    endfunction

    function automatic dip_t expect_dip(input status_t s, input logic pause);
        dip_t e;
        e.pause_n     = ~pause;
        e.flip        = s[ST_FLIP];
        e.test        = s[ST_TEST];
        e.fxlevel     = s[ST_FX_LSB+1:ST_FX_LSB];
        e.rot_control = s[ST_ROT];
        e.enable_fm   = ~s[ST_NO_FM];     // Status carries disable bits
        e.enable_psg  = ~s[ST_NO_PSG];
        return e;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Verification failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_game_in(input game_in_t exp, input string msg);
        if (game_in !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, game_in %h expected %h",
                                    $time, msg, game_in, exp));
        end
    endtask

    task automatic check_dip(input dip_t exp, input string msg);
        if (dip !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, dip %h expected %h",
                                    $time, msg, dip, exp));
        end
    endtask

    task automatic check_rst(input logic exp_rst, input logic exp_rst_n, input string msg);
        if (core_rst !== exp_rst || core_rst_n !== exp_rst_n) begin
            stop_on_error($sformatf("Fail at time %0t: %s, core_rst %b/%b expected %b/%b",
                                    $time, msg, core_rst, core_rst_n, exp_rst, exp_rst_n));
        end
    endtask

    task automatic check_gfx(input logic [GFX_LAYERS-1:0] exp, input string msg);
        if (gfx_en !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, gfx_en %b expected %b",
                                    $time, msg, gfx_en, exp));
        end
    endtask

    // n rising edges, then sample at the falling edge
    task automatic sample_after(input int n);
        repeat (n) @(posedge clk_sys);
        @(negedge clk_sys);
    endtask

    // Called at the last trigger edge
    task automatic check_stretch(input string msg);
        int i;
        for (i = 1; i <= RST_HOLD_CYCLES + 2; i++) begin
            sample_after(1);
            check_rst(i < RST_HOLD_CYCLES, i >= RST_HOLD_CYCLES + 2, msg);
        end
    endtask

    task automatic test_reset_stretch();
        dip_t after_rst;
        after_rst         = '0;
        after_rst.pause_n = 1'b1;
        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        check_rst(1'b1, 1'b0, "during game_rst");
        check_game_in('1, "game inputs during game_rst");
        check_dip(after_rst, "settings during game_rst");
        check_gfx('1, "layers during game_rst");
        @(posedge clk_sys);
        game_rst <= 1'b0;       // Fifth and last reset edge
        check_stretch("stretch after game_rst");
        @(posedge clk_sys);
        rst_req <= 1'b1;
        @(posedge clk_sys);
        rst_req <= 1'b0;
        check_stretch("stretch after rst_req");
        @(posedge clk_sys);
        downloading <= 1'b1;
        repeat (4) @(posedge clk_sys);
        downloading <= 1'b0;
        check_stretch("stretch after download");
    endtask

    task automatic test_settings_flip();
        status_t s;
        int i;
        for (i = 0; i < 10; i++) begin
            s          = random_word();
            s[ST_FLIP] = 1'b0;
            @(posedge clk_sys);
            status <= s;
            sample_after(1);
            check_dip(expect_dip(s, paused), "status decode");
        end
        s[ST_FLIP] = 1'b1;
        @(posedge clk_sys);
        status <= s;
        sample_after(1);
        check_dip(expect_dip(s, paused), "flip decode");
        check_rst(1'b0, 1'b1, "flip change before restart");
        @(posedge clk_sys);     // Old and new flip differ here
        check_stretch("stretch after flip change");
    endtask

    task automatic test_joysticks();
        status_t     s;
        board_joy_t  b1;
        board_joy_t  b2;
        key_t        k;
        logic [31:0] r;
        int          n;
        int          i;
        for (n = 0; n < 2; n++) begin
            s         = status;
            s[ST_ROT] = n[0];
            @(posedge clk_sys);
            status <= s;
            for (i = 0; i < 20; i++) begin
                r             = random_word();
                b1            = r[15:0];
                b2            = r[31:16];
                b1[PAUSE_BIT] = 1'b0;   // Pause has its own test
                b2[PAUSE_BIT] = 1'b0;
                r             = random_word();
                k             = '0;
                k.joy1        = r[9:0];
                k.joy2        = r[25:16];
                @(posedge clk_sys);
                board_joy1 <= b1;
                board_joy2 <= b2;
                keys       <= k;
                sample_after(2);
                check_game_in(expect_game_in(b1, b2, k, n[0]), "joystick merge");
            end
        end
    endtask

    task automatic test_coin_start();
        board_joy_t  b1;
        board_joy_t  b2;
        key_t        k;
        logic [31:0] r;
        int          i;
        for (i = 0; i < 16; i++) begin
            r              = random_word();
            b1             = '0;
            b2             = '0;
            k              = '0;
            b1[START1_BIT] = r[0];
            b1[START2_BIT] = r[1];
            b1[COIN_BIT]   = r[2];
            b2[START1_BIT] = r[3];
            b2[START2_BIT] = r[4];
            b2[COIN_BIT]   = r[5];
            k.start        = r[7:6];
            k.coin         = r[9:8];
            k.service      = r[10];
            @(posedge clk_sys);
            board_joy1 <= b1;
            board_joy2 <= b2;
            keys       <= k;
            sample_after(2);
            check_game_in(expect_game_in(b1, b2, k, status[ST_ROT]), "coin start service");
        end
    endtask

    task automatic test_pause_layers();
        int i;
        @(posedge clk_sys);
        board_joy1 <= '0;
        board_joy2 <= '0;
        keys       <= '0;
        sample_after(2);
        @(posedge clk_sys);
        keys.pause <= 1'b1;
        sample_after(1);
        check_dip(expect_dip(status, paused), "key pause too early");
        paused = ~paused;
        sample_after(1);
        check_dip(expect_dip(status, paused), "key pause");
        sample_after(4);
        check_dip(expect_dip(status, paused), "key pause held");
        @(posedge clk_sys);
        keys.pause <= 1'b0;
        sample_after(3);
        @(posedge clk_sys);
        board_joy1[PAUSE_BIT] <= 1'b1;
        sample_after(2);
        check_dip(expect_dip(status, paused), "board pause too early");
        paused = ~paused;
        sample_after(1);
        check_dip(expect_dip(status, paused), "board pause");
        @(posedge clk_sys);
        board_joy1[PAUSE_BIT] <= 1'b0;
        sample_after(3);
        // Board press one cycle ahead so both edges meet
        @(posedge clk_sys);
        board_joy2[PAUSE_BIT] <= 1'b1;
        @(posedge clk_sys);
        keys.pause <= 1'b1;
        paused = ~paused;
        sample_after(2);
        check_dip(expect_dip(status, paused), "pause from both sources");
        sample_after(3);
        check_dip(expect_dip(status, paused), "single toggle from both sources");
        check_gfx(layers, "layers before toggles");
        @(posedge clk_sys);
        board_joy2[PAUSE_BIT] <= 1'b0;
        keys.pause            <= 1'b0;
        for (i = 0; i < GFX_LAYERS; i++) begin
            @(posedge clk_sys);
            keys.gfx[i] <= 1'b1;
            layers[i] = ~layers[i];
            sample_after(1);
            check_gfx(layers, "layer toggle");
            sample_after(2);
            check_gfx(layers, "layer key held");
            @(posedge clk_sys);
            keys.gfx[i] <= 1'b0;
        end
    endtask

    task automatic test_soft_reset();
        @(posedge clk_sys);
        keys.reset <= 1'b1;
        @(posedge clk_sys);
        keys.reset <= 1'b0;
        @(negedge clk_sys);
        check_rst(1'b0, 1'b1, "soft reset too early");
        @(posedge clk_sys);     // soft_rst pulse seen here
        check_stretch("stretch after reset key");
        check_dip(expect_dip(status, paused), "pause through soft reset");
        check_gfx(layers, "layers through soft reset");
    endtask

    initial begin
        game_rst    = 1'b1;
        rst_req     = 1'b0;
        downloading = 1'b0;
        board_joy1  = '0;
        board_joy2  = '0;
        keys        = '0;
        status      = '0;
        paused      = 1'b0;
        layers      = '1;
        test_reset_stretch();
        test_settings_flip();
        test_joysticks();
        test_coin_start();
        test_pause_layers();
        test_soft_reset();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
